/* source/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam WORD_SIZE    = 32;
    localparam BLOCK_SIZE   = 2;
    localparam ASSOC        = 2;
    localparam CACHE_SIZE   = 1024;
    localparam N_SETS       = CACHE_SIZE / (ASSOC * BLOCK_SIZE * (WORD_SIZE / 8));
    localparam N_SET_BITS   = $clog2(N_SETS);
    localparam N_BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam N_TAG_BITS   = WORD_SIZE - N_SET_BITS - N_BLOCK_BITS - 2;

    // everything from here up bypasses the cache
    localparam logic [WORD_SIZE-1:0] NONCACHE_START_ADDR = 32'h8000_0000;

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef word_t [BLOCK_SIZE-1:0] block_t;
    typedef logic way_t;

    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        logic [N_SET_BITS-1:0]   set_idx;
        logic [N_BLOCK_BITS-1:0] block_off;
        logic [1:0]              byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [N_TAG_BITS-1:0] tag;
        block_t                data;
    } cache_frame_t;

    typedef struct packed {
        cache_frame_t [ASSOC-1:0] frames;
    } cache_set_t;

    // finish sits above set and way so the walk reads as one count
    typedef struct packed {
        logic                  finish;
        logic [N_SET_BITS-1:0] set_num;
        way_t                  way_num;
    } flush_idx_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        block_t     wdata;
        logic [3:0] byte_en;
    } mem_req_t;

    typedef struct packed {
        logic   dwait;
        block_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE, HIT, FETCH, WB, FLUSH_CACHE
    } cache_state_t;

endpackage

/* source/cache_data_array.sv */
`timescale 1ns/10ps

module cache_data_array (
    input  logic                             CLK,
    input  logic [cache_pkg::N_SET_BITS-1:0] sel,
    input  logic                             wen,
    input  cache_pkg::cache_set_t            wdata,
    input  cache_pkg::cache_set_t            wmask,
    output cache_pkg::cache_set_t            rdata
);

    // one entry per set, both ways side by side
    cache_pkg::cache_set_t sets [cache_pkg::N_SETS];
    cache_pkg::cache_set_t cur_set;
    cache_pkg::cache_set_t merged;

    assign cur_set = sets[sel];

    // read is combinational so the lookup sees the set in the same cycle
    assign rdata = cur_set;

    // mask bit high keeps the stored bit, low takes the new one
    always_comb begin
        merged = (cur_set & wmask) | (wdata & ~wmask);
    end

    always_ff @(posedge CLK) begin
        if (wen) begin
            sets[sel] <= merged;
        end
    end

endmodule

/* source/cache_lookup.sv */
`timescale 1ns/10ps

module cache_lookup (
    input  logic                   CLK,
    input  logic                   nRST,
    input  cache_pkg::cache_addr_t addr,
    input  cache_pkg::cache_set_t  set_rdata,
    input  logic                   touch,
    input  cache_pkg::way_t        touch_way,
    output logic                   hit,
    output cache_pkg::way_t        hit_way,
    output cache_pkg::way_t        victim_way,
    output logic                   pass_through
);

    // last used way per set
    logic [cache_pkg::N_SETS-1:0] last_used;
    cache_pkg::word_t             flat_addr;

    assign flat_addr    = addr;
    assign pass_through = flat_addr >= cache_pkg::NONCACHE_START_ADDR;

    // tag compare over both ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        if (!pass_through) begin
            for (int i = 0; i < cache_pkg::ASSOC; i++) begin
                if (set_rdata.frames[i].valid &&
                    set_rdata.frames[i].tag == addr.tag) begin
                    hit     = 1'b1;
                    hit_way = cache_pkg::way_t'(i);
                end
            end
        end
    end

    // replace whichever way was not touched last
    assign victim_way = ~last_used[addr.set_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_used <= '0;
        end else if (touch) begin
            last_used[addr.set_idx] <= touch_way;
        end
    end

endmodule

/* source/cache_flush_counter.sv */
`timescale 1ns/10ps

module cache_flush_counter (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  clear,
    input  logic                  advance,
    output cache_pkg::flush_idx_t flush_idx
);

    cache_pkg::flush_idx_t next_idx;
    logic                  last_way;
    logic                  last_set;

    assign last_way = int'(flush_idx.way_num) == cache_pkg::ASSOC - 1;
    assign last_set = int'(flush_idx.set_num) == cache_pkg::N_SETS - 1;

    // way first, then set; finish once the last frame is passed
    always_comb begin
        next_idx = flush_idx;
        if (clear) begin
            next_idx = '0;
        end else if (advance && !flush_idx.finish) begin
            if (last_way) begin
                next_idx.way_num = '0;
                if (last_set) begin
                    next_idx.set_num = '0;
                    next_idx.finish  = 1'b1;
                end else begin
                    next_idx.set_num = flush_idx.set_num + 1'b1;
                end
            end else begin
                next_idx.way_num = flush_idx.way_num + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            flush_idx <= '0;
        end else begin
            flush_idx <= next_idx;
        end
    end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/10ps

module cache_controller (
    input  logic                             CLK,
    input  logic                             nRST,
    input  cache_pkg::cpu_req_t              cpu_req,
    output cache_pkg::cpu_rsp_t              cpu_rsp,
    output cache_pkg::mem_req_t              mem_req,
    input  cache_pkg::mem_rsp_t              mem_rsp,
    input  logic                             flush,
    output logic                             flush_done,
    output logic                             cache_hit,
    output logic                             cache_miss,
    input  cache_pkg::cache_set_t            set_rdata,
    input  logic                             hit,
    input  cache_pkg::way_t                  hit_way,
    input  cache_pkg::way_t                  victim_way,
    input  logic                             pass_through,
    output logic [cache_pkg::N_SET_BITS-1:0] arr_sel,
    output logic                             arr_wen,
    output cache_pkg::cache_set_t            arr_wdata,
    output cache_pkg::cache_set_t            arr_wmask,
    output logic                             touch,
    output cache_pkg::way_t                  touch_way,
    output logic                             cnt_clear,
    output logic                             cnt_advance,
    input  cache_pkg::flush_idx_t            flush_idx
);

    cache_pkg::cache_state_t state, next_state;
    logic                    flush_req;
    logic                    flush_pend;
    logic                    req_valid;
    logic                    last_frame;
    cache_pkg::cache_addr_t  req_addr;
    cache_pkg::cache_addr_t  fill_addr;
    cache_pkg::cache_addr_t  wb_addr;
    cache_pkg::cache_addr_t  flush_addr;
    cache_pkg::cache_frame_t victim;
    cache_pkg::cache_frame_t flush_frame;

    // byte enables widened to a bit mask
    function automatic cache_pkg::word_t byte_mask(input logic [3:0] be);
        cache_pkg::word_t m;
        for (int i = 0; i < 4; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    assign req_addr    = cpu_req.addr;
    assign req_valid   = cpu_req.ren || cpu_req.wen;
    assign flush_pend  = flush || flush_req;
    assign victim      = set_rdata.frames[victim_way];
    assign flush_frame = set_rdata.frames[flush_idx.way_num];
    assign last_frame  = int'(flush_idx.set_num) == cache_pkg::N_SETS - 1 &&
                         int'(flush_idx.way_num) == cache_pkg::ASSOC - 1;

    // walk states index the array by the counter
    assign arr_sel = (state == cache_pkg::IDLE || state == cache_pkg::FLUSH_CACHE)
                     ? flush_idx.set_num : req_addr.set_idx;

    // block aligned addresses for fill, eviction and flush
    always_comb begin
        fill_addr          = '0;
        fill_addr.tag      = req_addr.tag;
        fill_addr.set_idx  = req_addr.set_idx;
        wb_addr            = fill_addr;
        wb_addr.tag        = victim.tag;
        flush_addr         = '0;
        flush_addr.tag     = flush_frame.tag;
        flush_addr.set_idx = flush_idx.set_num;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_pkg::IDLE;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (flush) begin
                flush_req <= 1'b1;
            end else if (flush_done) begin
                flush_req <= 1'b0;
            end
        end
    end

    always_comb begin
        next_state    = state;
        cpu_rsp.busy  = 1'b1;
        cpu_rsp.rdata = '0;
        mem_req       = '0;
        arr_wen       = 1'b0;
        arr_wdata     = '0;
        arr_wmask     = '1;
        touch         = 1'b0;
        touch_way     = hit_way;
        cnt_clear     = 1'b0;
        cnt_advance   = 1'b0;
        flush_done    = 1'b0;
        cache_hit     = 1'b0;
        cache_miss    = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                // zero one frame per cycle after reset
                arr_wen = 1'b1;
                arr_wmask.frames[flush_idx.way_num] = '0;
                cnt_advance = 1'b1;
                if (last_frame) begin
                    cnt_clear  = 1'b1;
                    next_state = cache_pkg::HIT;
                end
            end
            cache_pkg::HIT: begin
                if (flush_pend) begin
                    next_state = cache_pkg::FLUSH_CACHE;
                end else if (cpu_req.ren && hit) begin
                    cpu_rsp.busy  = 1'b0;
                    cpu_rsp.rdata = set_rdata.frames[hit_way].data[req_addr.block_off];
                    touch         = 1'b1;
                    cache_hit     = 1'b1;
                end else if (cpu_req.wen && hit) begin
                    cpu_rsp.busy = 1'b0;
                    arr_wen      = 1'b1;
                    arr_wdata.frames[hit_way].data[req_addr.block_off] = cpu_req.wdata;
                    arr_wdata.frames[hit_way].dirty = 1'b1;
                    arr_wmask.frames[hit_way].data[req_addr.block_off] =
                        ~byte_mask(cpu_req.byte_en);
                    arr_wmask.frames[hit_way].dirty = 1'b0;
                    touch     = 1'b1;
                    cache_hit = 1'b1;
                end else if (pass_through && req_valid) begin
                    // single word straight to memory, lane 0
                    mem_req.ren      = cpu_req.ren;
                    mem_req.wen      = cpu_req.wen;
                    mem_req.addr     = cpu_req.addr;
                    mem_req.wdata[0] = cpu_req.wdata & byte_mask(cpu_req.byte_en);
                    mem_req.byte_en  = cpu_req.byte_en;
                    cpu_rsp.busy     = mem_rsp.dwait;
                    cpu_rsp.rdata    = mem_rsp.rdata[0];
                end else if (req_valid) begin
                    next_state = (victim.valid && victim.dirty) ? cache_pkg::WB
                                                                : cache_pkg::FETCH;
                end
            end
            cache_pkg::WB: begin
                mem_req.wen     = 1'b1;
                mem_req.addr    = wb_addr;
                mem_req.wdata   = victim.data;
                mem_req.byte_en = '1;
                if (!mem_rsp.dwait) begin
                    next_state = cache_pkg::FETCH;
                end
            end
            cache_pkg::FETCH: begin
                mem_req.ren     = 1'b1;
                mem_req.addr    = fill_addr;
                mem_req.byte_en = '1;
                if (!mem_rsp.dwait) begin
                    // fill the victim way, the request then hits
                    arr_wen = 1'b1;
                    arr_wmask.frames[victim_way]       = '0;
                    arr_wdata.frames[victim_way].valid = 1'b1;
                    arr_wdata.frames[victim_way].dirty = cpu_req.wen;
                    arr_wdata.frames[victim_way].tag   = req_addr.tag;
                    arr_wdata.frames[victim_way].data  = mem_rsp.rdata;
                    cache_miss = 1'b1;
                    next_state = cache_pkg::HIT;
                end
            end
            cache_pkg::FLUSH_CACHE: begin
                if (flush_idx.finish) begin
                    flush_done = 1'b1;
                    cnt_clear  = 1'b1;
                    next_state = cache_pkg::HIT;
                end else if (flush_frame.valid && flush_frame.dirty) begin
                    mem_req.wen     = 1'b1;
                    mem_req.addr    = flush_addr;
                    mem_req.wdata   = flush_frame.data;
                    mem_req.byte_en = '1;
                    if (!mem_rsp.dwait) begin
                        arr_wen     = 1'b1;
                        arr_wmask.frames[flush_idx.way_num] = '0;
                        cnt_advance = 1'b1;
                    end
                end else begin
                    // clean or invalid frame, just zero it
                    arr_wen     = 1'b1;
                    arr_wmask.frames[flush_idx.way_num] = '0;
                    cnt_advance = 1'b1;
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

endmodule

/* source/l1_cache.sv */
`timescale 1ns/10ps

module l1_cache (
    input  logic                CLK,
    input  logic                nRST,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp,
    input  logic                flush,
    output logic                flush_done,
    output logic                cache_hit,
    output logic                cache_miss
);

    cache_pkg::cache_addr_t          req_addr;
    cache_pkg::cache_set_t           set_rdata;
    cache_pkg::cache_set_t           arr_wdata;
    cache_pkg::cache_set_t           arr_wmask;
    logic [cache_pkg::N_SET_BITS-1:0] arr_sel;
    logic                            arr_wen;
    logic                            hit;
    logic                            pass_through;
    cache_pkg::way_t                 hit_way;
    cache_pkg::way_t                 victim_way;
    logic                            touch;
    cache_pkg::way_t                 touch_way;
    logic                            cnt_clear;
    logic                            cnt_advance;
    cache_pkg::flush_idx_t           flush_idx;

    assign req_addr = cpu_req.addr;

    cache_data_array i_data_array (
        .CLK   (CLK),
        .sel   (arr_sel),
        .wen   (arr_wen),
        .wdata (arr_wdata),
        .wmask (arr_wmask),
        .rdata (set_rdata)
    );

    cache_lookup i_lookup (
        .CLK          (CLK),
        .nRST         (nRST),
        .addr         (req_addr),
        .set_rdata    (set_rdata),
        .touch        (touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .pass_through (pass_through)
    );

    cache_flush_counter i_flush_counter (
        .CLK       (CLK),
        .nRST      (nRST),
        .clear     (cnt_clear),
        .advance   (cnt_advance),
        .flush_idx (flush_idx)
    );

    cache_controller i_controller (
        .CLK          (CLK),
        .nRST         (nRST),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .flush        (flush),
        .flush_done   (flush_done),
        .cache_hit    (cache_hit),
        .cache_miss   (cache_miss),
        .set_rdata    (set_rdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .pass_through (pass_through),
        .arr_sel      (arr_sel),
        .arr_wen      (arr_wen),
        .arr_wdata    (arr_wdata),
        .arr_wmask    (arr_wmask),
        .touch        (touch),
        .touch_way    (touch_way),
        .cnt_clear    (cnt_clear),
        .cnt_advance  (cnt_advance),
        .flush_idx    (flush_idx)
    );

endmodule

/* sim/l1_cache_assertions.sv */
`timescale 1ns/10ps

module l1_cache_assertions (
    input logic                CLK,
    input logic                nRST,
    input cache_pkg::mem_req_t mem_req,
    input cache_pkg::mem_rsp_t mem_rsp,
    input logic                cache_hit,
    input logic                cache_miss
);

    // count of failed assertions
    int fail_count = 0;

    // one direction per memory transfer
    no_read_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen))
        else begin
            fail_count++;
            $error("memory read and write requested in the same cycle");
        end

    // a fill never reports a hit and the held request hits right after
    miss_then_hit: assert property (@(posedge CLK) disable iff (!nRST)
        cache_miss |-> !cache_hit ##1 cache_hit)
        else begin
            fail_count++;
            $error("cache miss raised with a hit or not followed by a hit");
        end

    // a stalled request holds every field
    stable_while_wait: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_req.ren || mem_req.wen) && mem_rsp.dwait |=> $stable(mem_req))
        else begin
            fail_count++;
            $error("memory request changed while wait was high");
        end

endmodule

/* sim/tb_l1_cache.sv */
`timescale 1ns/10ps

module tb_l1_cache;

    localparam int CLK_PERIOD = 20;

    logic                CLK;
    logic                nRST;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::cpu_rsp_t cpu_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp = '{dwait: 1'b1, rdata: '0};
    logic                flush;
    logic                flush_done;
    logic                cache_hit;
    logic                cache_miss;

    // memory model and shadow memory are word addressed
    logic [31:0] mem_words [logic [29:0]];
    logic [31:0] shadow [logic [29:0]];

    int          errors = 0;
    int          issued = 0;
    int          hit_count = 0;
    int          miss_count = 0;
    int          wait_cnt = 1;
    string       test_name = "reset";
    logic [29:0] mem_idx = '0;
    logic [31:0] last_mem_addr = '0;
    logic [3:0]  last_mem_be = '0;

    l1_cache i_l1_cache (
        .CLK        (CLK),
        .nRST       (nRST),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done),
        .cache_hit  (cache_hit),
        .cache_miss (cache_miss)
    );

    bind l1_cache l1_cache_assertions i_assertions (
        .CLK        (CLK),
        .nRST       (nRST),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .cache_hit  (cache_hit),
        .cache_miss (cache_miss)
    );

    // untouched words read back as a pattern of their whole address
    function automatic logic [31:0] fill_word(input logic [29:0] idx);
        return ({2'b00, idx} * 32'h9E37_79B1) ^ 32'h5131_A5C3;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] mem_word(input logic [29:0] idx);
        if (mem_words.exists(idx)) begin
            return mem_words[idx];
        end
        return fill_word(idx);
    endfunction

    // expected read value from the shadow memory
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return fill_word(addr[31:2]);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one request held until an edge with busy low
    task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] be, output int cycles);
        cycles = 0;
        issued++;
        cpu_req.ren     = !wr;
        cpu_req.wen     = wr;
        cpu_req.addr    = addr;
        cpu_req.wdata   = wdata;
        cpu_req.byte_en = be;
        do begin
            @(posedge CLK);
            cycles++;
        end while (cpu_rsp.busy);
        @(negedge CLK);
        cpu_req.ren = 1'b0;
        cpu_req.wen = 1'b0;
    endtask

    task automatic flush_all();
        issued++;
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
        do begin
            @(posedge CLK);
        end while (!flush_done);
        @(negedge CLK);
    endtask

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    // memory model commits on an edge with wait low and counts down otherwise
    always @(posedge CLK) begin
        if (mem_req.ren || mem_req.wen) begin
            if (!mem_rsp.dwait) begin
                if (mem_req.wen && mem_req.addr >= cache_pkg::NONCACHE_START_ADDR) begin
                    mem_words[mem_req.addr[31:2]] = merge_bytes(mem_word(mem_req.addr[31:2]),
                                                    mem_req.wdata[0], mem_req.byte_en);
                end else if (mem_req.wen) begin
                    mem_words[{mem_req.addr[31:3], 1'b0}] = mem_req.wdata[0];
                    mem_words[{mem_req.addr[31:3], 1'b1}] = mem_req.wdata[1];
                end
                last_mem_addr = mem_req.addr;
                last_mem_be   = mem_req.byte_en;
                wait_cnt      = $urandom_range(4, 1);
            end else begin
                wait_cnt--;
                mem_idx = mem_req.addr[31:2];
            end
        end
    end

    always @(negedge CLK) begin
        mem_rsp.dwait    = wait_cnt != 0;
        mem_rsp.rdata[0] = mem_word(mem_idx);
        mem_rsp.rdata[1] = mem_word(mem_idx + 30'd1);
    end

    // compare completed reads and track completed writes
    always @(posedge CLK) begin
        if (nRST) begin
            if (cache_hit) begin
                hit_count++;
            end
            if (cache_miss) begin
                miss_count++;
            end
            if (cpu_req.ren && !cpu_rsp.busy) begin
                check_value(test_name, expected_read(cpu_req.addr), cpu_rsp.rdata);
            end
            if (cpu_req.wen && !cpu_rsp.busy) begin
                shadow[cpu_req.addr[31:2]] = merge_bytes(expected_read(cpu_req.addr),
                                                         cpu_req.wdata, cpu_req.byte_en);
            end
        end
    end

    initial begin
        int          cycles;
        int          hits_before;
        int          misses_before;
        int          assert_fails;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be_list [7];

        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                    4'b0011, 4'b1100, 4'b1111};
        void'($urandom(32'h5131));
        nRST    = 1'b0;
        cpu_req = '0;
        flush   = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // first read misses and the repeat hits at once
        test_name     = "first_read";
        misses_before = miss_count;
        access(1'b0, 32'h0000_0100, '0, 4'hf, cycles);
        check_value("first_read_misses", 1, miss_count - misses_before);
        hits_before = hit_count;
        access(1'b0, 32'h0000_0100, '0, 4'hf, cycles);
        check_value("repeat_read_hits", 1, hit_count - hits_before);
        check_value("repeat_read_cycles", 1, cycles);

        test_name = "byte_enables";
        foreach (be_list[i]) begin
            data = $urandom();
            access(1'b1, 32'h0000_1044, data, be_list[i], cycles);
            access(1'b0, 32'h0000_1044, '0, 4'hf, cycles);
        end

        // three blocks in set 1 so the third write evicts the first
        test_name = "eviction";
        for (int i = 0; i < 3; i++) begin
            access(1'b1, 32'h0000_2008 + i * 32'h200, $urandom(), 4'hf, cycles);
        end
        addr = 32'h0000_2008;
        check_value("evicted_in_memory", expected_read(addr), mem_word(addr[31:2]));
        for (int i = 0; i < 3; i++) begin
            access(1'b0, 32'h0000_2008 + i * 32'h200, '0, 4'hf, cycles);
        end

        test_name = "flush";
        addr      = '0;
        for (int i = 0; i < 12; i++) begin
            addr = $urandom() & 32'h0000_3FFC;
            access(1'b1, addr, $urandom(), 4'hf, cycles);
        end
        flush_all();
        foreach (shadow[idx]) begin
            check_value("flush_memory", shadow[idx], mem_word(idx));
        end
        misses_before = miss_count;
        access(1'b0, addr, '0, 4'hf, cycles);
        check_value("read_after_flush_misses", 1, miss_count - misses_before);

        // single word straight to memory without hit or miss
        test_name     = "pass_through";
        hits_before   = hit_count;
        misses_before = miss_count;
        addr          = 32'h8000_0014;
        access(1'b1, addr, $urandom(), 4'b0110, cycles);
        check_value("pass_through_addr", addr, last_mem_addr);
        check_value("pass_through_byte_en", 32'(4'b0110), 32'(last_mem_be));
        check_value("pass_through_memory", expected_read(addr), mem_word(addr[31:2]));
        access(1'b0, addr, '0, 4'hf, cycles);
        check_value("pass_through_hits", hits_before, hit_count);
        check_value("pass_through_misses", misses_before, miss_count);

        assert_fails = i_l1_cache.i_assertions.fail_count;
        $display("closing: %0d errors and %0d assertion failures over %0d requests",
                 errors, assert_fails, issued);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // 200 cycles per request plus the reset clear and slack
    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= 200 * issued + 2000) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the cache did not answer within %0d cycles", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* sources.f */
source/cache_pkg.sv
source/cache_data_array.sv
source/cache_lookup.sv
source/cache_flush_counter.sv
source/cache_controller.sv
source/l1_cache.sv
sim/l1_cache_assertions.sv
sim/tb_l1_cache.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_cache -f sources.f -o sim_l1_cache

status=0
./obj_dir/sim_l1_cache > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
